/* packet_reduce.f */
design/reduce_pkg.sv
design/flow_if.sv
design/flow_reg_fwd.sv
design/frame_ctrl.sv
design/beat_counter.sv
design/packet_accum.sv
design/packet_reduce_top.sv
verif/packet_reduce_props.sv
verif/packet_reduce_tb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = packet_reduce_tb
FLIST = packet_reduce.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed."; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "Simulation ended without a verdict."; exit 1; fi
	@echo "Simulation passed."

clean:
	rm -rf $(BUILD) $(LOG)

/* verif/packet_reduce_tb.sv */
module packet_reduce_tb
  import reduce_pkg::*;
();

  // One beat of the result stream, as the model predicts or the DUT emits it.
  typedef struct packed {
    logic [data_width-1:0]  result;
    logic [count_width-1:0] length;
    logic                   overrun;
  } result_t;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   in_valid;
  logic                   in_ready;
  logic [data_width-1:0]  in_data;
  logic                   in_last;
  op_e                    in_op;
  logic                   out_valid;
  logic                   out_ready;
  logic [data_width-1:0]  out_result;
  logic [count_width-1:0] out_length;
  logic                   out_overrun;

  int seed = 93;
  int timeout_cycles = 200;
  int errors = 0;
  int errors_at_start = 0;
  int checks = 0;
  int tests = 0;

  // Predictions and observed results, both kept in packet order.
  result_t want_q[$];
  result_t seen_q[$];

  packet_reduce_top i_dut (.*);

  always #2 clk = ~clk;

  // --------------------------------------------------------------------
  // Output monitor
  // --------------------------------------------------------------------

  // Values are read before the edge updates the DUT, so each entry is
  // exactly the beat that crossed the output handshake.
  always @(posedge clk) begin
    if (!reset && out_valid && out_ready) begin
      seen_q.push_back({out_result, out_length, out_overrun});
    end
  end

  // --------------------------------------------------------------------
  // Driver, model and checker
  // --------------------------------------------------------------------

  // Drives n random words as one packet, starting on a falling edge.
  // The prediction folds only the first max_beats words, by the first opcode.
  task automatic send_packet(input int n, input op_e first_op, input op_e later_op);
    logic [data_width-1:0] word;
    logic [data_width-1:0] acc;
    int                    waits;
    acc = '0;
    for (int i = 0; i < n; i++) begin
      word = data_width'($random(seed));
      if (i < max_beats) begin
        acc = (first_op == op_xor) ? (acc ^ word) : (acc + word);
      end
      in_valid = 1'b1;
      in_data  = word;
      in_last  = (i == n - 1);
      in_op    = (i == 0) ? first_op : later_op;
      // in_ready only moves on a rising edge, so it is settled here.
      waits = 0;
      while (!in_ready && waits < timeout_cycles) begin
        @(negedge clk);
        waits++;
      end
      if (!in_ready) begin
        $display("Error at %0t: the input stream stalled and beat %0d was never taken",
                 $time, i);
        errors++;
        break;
      end
      @(negedge clk);
    end
    in_valid = 1'b0;
    want_q.push_back({acc, count_width'(n > max_beats ? max_beats : n), n > max_beats});
  endtask

  // Waits for the next result and compares it with the oldest prediction.
  task automatic expect_result(input string label);
    result_t want;
    result_t seen;
    int      waits;
    want  = want_q.pop_front();
    waits = 0;
    while (seen_q.size() == 0 && waits < timeout_cycles) begin
      @(negedge clk);
      waits++;
    end
    checks++;
    if (seen_q.size() == 0) begin
      $display("Error at %0t: no result arrived for %s", $time, label);
      errors++;
    end else begin
      seen = seen_q.pop_front();
      assert (seen == want) else begin
        $display("Fail %0t: %s got %h len %0d ovr %b, expected %h len %0d ovr %b",
                 $time, label, seen.result, seen.length, seen.overrun,
                 want.result, want.length, want.overrun);
        errors++;
      end
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %s finished with %0d errors", name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  // --------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------

  task automatic test_sum_packets();
    out_ready = 1'b1;
    send_packet(1, op_sum, op_sum);
    expect_result("sum of 1");
    send_packet(3, op_sum, op_sum);
    expect_result("sum of 3");
    send_packet(max_beats, op_sum, op_sum);
    expect_result("sum of max_beats");
    report_test("sum packets");
  endtask

  // Later beats carry the other opcode, which must be ignored.
  task automatic test_xor_packets();
    send_packet(5, op_xor, op_sum);
    expect_result("xor with sum beats");
    send_packet(4, op_sum, op_xor);
    expect_result("sum with xor beats");
    report_test("xor packets");
  endtask

  // The four dropped words must not leak into the following packet.
  task automatic test_overrun();
    send_packet(12, op_sum, op_sum);
    expect_result("overrun");
    send_packet(3, op_xor, op_xor);
    expect_result("after overrun");
    report_test("overrun");
  endtask

  task automatic test_latency();
    send_packet(4, op_sum, op_sum);
    // The last beat crossed one edge ago and now sits in the flow register.
    checks += 2;
    assert (!out_valid) else begin
      $display("Fail %0t: out_valid rose one cycle after the last beat", $time);
      errors++;
    end
    @(negedge clk);
    assert (out_valid) else begin
      $display("Fail %0t: out_valid low two cycles after the last beat", $time);
      errors++;
    end
    expect_result("latency");
    report_test("latency");
  endtask

  task automatic test_back_pressure();
    out_ready = 1'b0;
    // The first packet parks in emit, and the one beat of the second
    // fills the flow register with nowhere to go.
    send_packet(3, op_sum, op_sum);
    send_packet(1, op_xor, op_xor);
    repeat (4) @(negedge clk);
    checks++;
    assert (!in_ready && out_valid) else begin
      $display("Fail %0t: in_ready %b and out_valid %b while results are held",
               $time, in_ready, out_valid);
      errors++;
    end
    out_ready = 1'b1;
    send_packet(2, op_sum, op_xor);
    expect_result("held sum");
    expect_result("held xor");
    expect_result("after release");
    report_test("back pressure");
  endtask

  initial begin
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    in_last   = 1'b0;
    in_op     = op_sum;
    out_ready = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_sum_packets();
    test_xor_packets();
    test_overrun();
    test_latency();
    test_back_pressure();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verif/packet_reduce_props.sv */
module packet_reduce_props
  import reduce_pkg::*;
(
  input logic                   clk,
  input logic                   reset,
  input logic                   in_valid,
  input logic                   in_ready,
  input logic [data_width-1:0]  in_data,
  input logic                   stage_valid,
  input logic                   stage_ready,
  input logic [data_width-1:0]  stage_data,
  input logic                   out_valid,
  input logic                   out_ready,
  input logic [data_width-1:0]  out_result,
  input logic [count_width-1:0] out_length,
  input logic                   out_overrun
);

  // --------------------------------------------------------------------
  // Flow register
  // --------------------------------------------------------------------

  // The flow register leaves reset empty, so the input can always move.
  in_ready_after_reset: assert property (@(posedge clk) reset |=> in_ready)
    else $error("in_ready is low right after reset");

  // An accepted beat shows up on the stage side one cycle later, unchanged.
  cut_through: assert property (@(posedge clk) disable iff (reset)
    in_valid && in_ready |=> stage_valid && (stage_data == $past(in_data)))
    else $error("accepted beat did not reach the stage one cycle later");

  // Back-pressure is combinational. A ready consumer always frees the input.
  ready_path: assert property (@(posedge clk) disable iff (reset)
    stage_ready |-> in_ready)
    else $error("stage ready is high while in_ready is low");

  // --------------------------------------------------------------------
  // Result stream
  // --------------------------------------------------------------------

  // An offered result holds still until the sink takes it.
  result_stable: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_result)
      && $stable(out_length) && $stable(out_overrun))
    else $error("result changed or vanished before out_ready");

endmodule

// The stage side of the flow register is only visible through its interface.
bind packet_reduce_top packet_reduce_props i_props (
  .*,
  .stage_valid (stage_flow.valid),
  .stage_ready (stage_flow.ready),
  .stage_data  (stage_flow.data)
);

/* design/packet_reduce_top.sv */
module packet_reduce_top
  import reduce_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,

  // Input stream.
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic [data_width-1:0]  in_data,
  input  logic                   in_last,
  input  op_e                    in_op,

  // Result stream.
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic [data_width-1:0]  out_result,
  output logic [count_width-1:0] out_length,
  output logic                   out_overrun
);

  logic start;
  logic take;
  logic at_limit;

  // --------------------------------------------------------------------
  // Streams
  // --------------------------------------------------------------------

  // Input side of the flow register, fed straight from the ports.
  flow_if in_flow ();

  // Registered side of the flow register, consumed by the FSM.
  flow_if stage_flow ();

  assign in_flow.valid = in_valid;
  assign in_flow.data  = in_data;
  assign in_flow.last  = in_last;
  assign in_flow.op    = in_op;
  assign in_ready      = in_flow.ready;

  // --------------------------------------------------------------------
  // Instances
  // --------------------------------------------------------------------

  // Cuts the input timing and buffers one beat during emit.
  flow_reg_fwd #(
    .width (stage_width)
  ) i_flow_reg (
    .clk   (clk),
    .reset (reset),
    .push  (in_flow.sink),
    .pop   (stage_flow.source)
  );

  frame_ctrl i_frame_ctrl (
    .clk         (clk),
    .reset       (reset),
    .stage       (stage_flow.sink),
    .at_limit    (at_limit),
    .start       (start),
    .take        (take),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_overrun (out_overrun)
  );

  // The held count is the packet length reported with the result.
  beat_counter i_beat_counter (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .take     (take),
    .count    (out_length),
    .at_limit (at_limit)
  );

  packet_accum i_packet_accum (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .take   (take),
    .data   (stage_flow.data),
    .op     (stage_flow.op),
    .result (out_result)
  );

endmodule

/* design/packet_accum.sv */
module packet_accum
  import reduce_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic                  take,
  input  logic [data_width-1:0] data,
  input  op_e                   op,
  output logic [data_width-1:0] result
);

  op_e                   op_q;
  logic [data_width-1:0] folded;

  // --------------------------------------------------------------------
  // Opcode latch
  // --------------------------------------------------------------------

  // Only the first beat picks the reduction. Opcodes on later beats of
  // the same packet are ignored.
  always_ff @(posedge clk) begin
    if (reset) begin
      op_q <= op_sum;
    end else if (start) begin
      op_q <= op;
    end
  end

  // --------------------------------------------------------------------
  // Fold
  // --------------------------------------------------------------------

  // Combine the running result with the incoming word.
  // The sum simply wraps at the word width.
  always_comb begin
    case (op_q)
      op_xor: begin
        folded = result ^ data;
      end
      default: begin
        folded = result + data;
      end
    endcase
  end

  // --------------------------------------------------------------------
  // Result register
  // --------------------------------------------------------------------

  // The first word seeds the result directly. Take is also high with
  // start, so start has to win here.
  // With neither strobe the result holds, which keeps it steady for emit.
  always_ff @(posedge clk) begin
    if (start) begin
      result <= data;
    end else if (take) begin
      result <= folded;
    end
  end

endmodule

/* design/beat_counter.sv */
module beat_counter
  import reduce_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic                   take,
  output logic [count_width-1:0] count,
  output logic                   at_limit
);

  logic [count_width-1:0] count_next;

  // --------------------------------------------------------------------
  // Count update
  // --------------------------------------------------------------------

  // The first beat of a packet counts as one; later beats add one each.
  assign count_next = start ? count_width'(1) : count + 1'b1;

  // Flag the beat that brings the count up to the limit. The controller
  // uses it in the same cycle to decide whether to cut the packet.
  assign at_limit = take && (count_next == count_width'(max_beats));

  // The count holds while the result is emitted, so it doubles as the
  // packet length on the output stream.
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (start || take) begin
      count <= count_next;
    end
  end

endmodule

/* design/frame_ctrl.sv */
module frame_ctrl
  import reduce_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  flow_if.sink  stage,
  input  logic  at_limit,
  output logic  start,
  output logic  take,
  output logic  out_valid,
  input  logic  out_ready,
  output logic  out_overrun
);

  frame_state_e state;
  frame_state_e state_next;
  logic         overrun_q;
  logic         overrun_next;
  logic         beat_fire;
  logic         in_packet;

  // --------------------------------------------------------------------
  // Stage handshake and datapath strobes
  // --------------------------------------------------------------------

  // Beats are accepted in every state except while a result is on offer.
  // The next packet therefore waits in the flow register during emit.
  assign stage.ready = (state != st_emit);
  assign beat_fire   = stage.valid && stage.ready;

  // Idle and accum are the states in which a beat belongs to the result.
  assign in_packet = (state == st_idle) || (state == st_accum);

  // A beat in idle opens a packet. Beats swallowed in drop are neither.
  assign start = beat_fire && (state == st_idle);
  assign take  = beat_fire && in_packet;

  // The result is offered for exactly as long as the FSM sits in emit.
  assign out_valid   = (state == st_emit);
  assign out_overrun = overrun_q;

  // --------------------------------------------------------------------
  // Next-state logic
  // --------------------------------------------------------------------

  always_comb begin
    state_next   = state;
    overrun_next = overrun_q;
    case (state)
      st_idle, st_accum: begin
        if (beat_fire) begin
          // A last beat closes the packet normally. Reaching the limit
          // without last cuts the packet and marks the result.
          if (stage.last || at_limit) begin
            state_next   = st_emit;
            overrun_next = at_limit && !stage.last;
          end else begin
            state_next = st_accum;
          end
        end
      end
      st_emit: begin
        // A cut packet still has beats upstream, so go and discard them.
        if (out_ready) begin
          if (overrun_q) begin
            state_next = st_drop;
          end else begin
            state_next = st_idle;
          end
        end
      end
      st_drop: begin
        // Discard everything up to and including the last beat.
        if (beat_fire && stage.last) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  // --------------------------------------------------------------------
  // State registers
  // --------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      overrun_q <= 1'b0;
    end else begin
      state     <= state_next;
      overrun_q <= overrun_next;
    end
  end

endmodule

/* design/flow_reg_fwd.sv */
module flow_reg_fwd
  import reduce_pkg::*;
#(
  parameter int width = stage_width
) (
  input logic    clk,
  input logic    reset,
  flow_if.sink   push,
  flow_if.source pop
);

  logic             valid_q;
  logic             valid_next;
  logic             push_fire;
  logic [width-1:0] push_bus;
  logic [width-1:0] data_q;

  // --------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------

  // The stage takes a beat when it is empty or when its content leaves in the
  // same cycle. This keeps the back-pressure path purely combinational.
  assign push.ready = pop.ready || !valid_q;
  assign push_fire  = push.valid && push.ready;

  // The register stays full if it cannot drain, and fills on any new push.
  assign valid_next = push.valid || !push.ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_next;
    end
  end

  // --------------------------------------------------------------------
  // Payload
  // --------------------------------------------------------------------

  // The beat is packed as {data, last, op} while it sits in the stage.
  assign push_bus = {push.data, push.last, push.op};

  // Load only on a real transfer; valid_q says whether the content is live.
  always_ff @(posedge clk) begin
    if (push_fire) begin
      data_q <= push_bus;
    end
  end

  assign pop.valid = valid_q;
  assign pop.data  = data_q[width-1 -: data_width];
  assign pop.last  = data_q[$bits(op_e)];
  assign pop.op    = op_e'(data_q[$bits(op_e)-1:0]);

endmodule

/* design/flow_if.sv */
interface flow_if
  import reduce_pkg::*;
();

  // Handshake pair. A beat moves in a cycle where both are high.
  logic                  valid;
  logic                  ready;

  // Payload of one beat.
  logic [data_width-1:0] data;
  logic                  last;
  op_e                   op;

  // The producer side drives valid and the payload.
  modport source (
    output valid,
    output data,
    output last,
    output op,
    input  ready
  );

  // The consumer side only drives ready.
  modport sink (
    input  valid,
    input  data,
    input  last,
    input  op,
    output ready
  );

endinterface

/* design/reduce_pkg.sv */
package reduce_pkg;

  // --------------------------------------------------------------------
  // Datapath sizes
  // --------------------------------------------------------------------

  // Width of one stream word and of the reduced result.
  localparam int data_width = 16;

  // Longest packet that is reduced in full. Longer packets are cut here.
  localparam int max_beats = 8;

  // Width of the beat count. It must hold the values 1 to max_beats.
  localparam int count_width = 4;

  // --------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------

  // Reduction selected by the first beat of a packet.
  typedef enum logic {
    op_sum = 1'b0,
    op_xor = 1'b1
  } op_e;

  // Framing states of the packet controller.
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_accum = 2'd1,
    st_emit  = 2'd2,
    st_drop  = 2'd3
  } frame_state_e;

  // Packed width of one staged beat, laid out as {data, last, op}.
  localparam int stage_width = data_width + 1 + $bits(op_e);

endpackage
